/* hw/pi_pkg.sv */
package pi_pkg;

    // Memory base of the save window
    localparam logic [31:0] save_offset = 32'h03FE_0000;

    // Window bounds in the upper address half
    localparam logic [15:0] rom_base_hi  = 16'h1000;
    localparam logic [15:0] rom_end_hi   = 16'h13FF;
    localparam logic [15:0] sram_base_hi = 16'h0800;
    localparam logic [15:0] sram_end_hi  = 16'h0801;
    localparam logic [15:0] cfg_hi       = 16'h1FFF;

    localparam int fifo_depth  = 4;
    localparam int fifo_addr_w = $clog2(fifo_depth);

    typedef enum logic [1:0] {
        port_none,
        port_mem,
        port_reg
    } pi_port_e;

    // Encoded as {aleh, alel}
    typedef enum logic [1:0] {
        mode_idle  = 2'b10,
        mode_high  = 2'b11,
        mode_low   = 2'b01,
        mode_valid = 2'b00
    } pi_mode_e;

    typedef struct packed {
        logic aleh_op;
        logic alel_op;
        logic read_op;
        logic write_op;
        logic end_op;
    } pi_events_t;

    typedef struct packed {
        logic sram_enabled;
        logic rom_write_enabled;
        logic cfg_unlock;
    } pi_cfg_t;

    typedef struct packed {
        pi_port_e    read_port;
        pi_port_e    write_port;
        logic [31:0] mem_offset;
    } pi_decode_t;

    typedef struct packed {
        logic        request;
        logic        write;
        logic [31:0] address;
        logic [15:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic        select;
        logic        read;
        logic        write;
        logic [16:0] address;
        logic [15:0] wdata;
    } reg_req_t;

endpackage

/* hw/pi_sync_events.sv */
`timescale 1ns/1ps

module pi_sync_events (
    input  logic               clk,
    input  logic               pi_reset,
    input  logic               n64_reset,
    input  logic               pi_aleh,
    input  logic               pi_alel,
    input  logic               pi_read,
    input  logic               pi_write,
    output pi_pkg::pi_events_t events,
    output logic               console_on,
    output pi_pkg::pi_mode_e   mode
);

    logic [1:0] reset_ff;
    logic [2:0] aleh_ff;
    logic [2:0] alel_ff;
    logic [1:0] read_ff;
    logic [2:0] write_ff;

    pi_pkg::pi_mode_e last_mode;
    logic             last_read;
    logic             last_write;

    // Read gets one stage less so the data path has more time before the rising edge
    always_ff @(posedge clk) begin
        reset_ff <= {reset_ff[0], n64_reset};
        aleh_ff  <= {aleh_ff[1:0], pi_aleh};
        alel_ff  <= {alel_ff[1:0], pi_alel};
        read_ff  <= {read_ff[0], pi_read};
        write_ff <= {write_ff[1:0], pi_write};
    end

    assign console_on = reset_ff[1];
    assign mode = pi_pkg::pi_mode_e'({aleh_ff[2], alel_ff[2]});

    always_ff @(posedge clk) begin
        if (!pi_reset) begin
            events     <= '0;
            last_mode  <= pi_pkg::mode_idle;
            last_read  <= 1'b1;
            last_write <= 1'b1;
        end else begin
            last_mode  <= mode;
            last_read  <= read_ff[1];
            last_write <= write_ff[2];

            events.aleh_op <= console_on && (last_mode != pi_pkg::mode_high)
                && (mode == pi_pkg::mode_high);
            events.alel_op <= console_on && (last_mode == pi_pkg::mode_high)
                && (mode == pi_pkg::mode_low);
            // Strobe falling edges only count inside the data phase
            events.read_op <= console_on && (mode == pi_pkg::mode_valid)
                && last_read && !read_ff[1];
            events.write_op <= console_on && (mode == pi_pkg::mode_valid)
                && last_write && !write_ff[2];
            events.end_op <= console_on && (last_mode == pi_pkg::mode_valid)
                && (mode != pi_pkg::mode_valid);
        end
    end

endmodule

/* hw/pi_addr_decode.sv */
`timescale 1ns/1ps

module pi_addr_decode (
    input  logic               clk,
    input  logic               pi_reset,
    input  pi_pkg::pi_events_t events,
    input  logic [15:0]        ad_in,
    input  pi_pkg::pi_cfg_t    cfg,
    output pi_pkg::pi_decode_t decode,
    output logic               reg_select
);

    logic in_rom;
    logic in_sram;
    logic in_cfg;

    assign in_rom  = (ad_in >= pi_pkg::rom_base_hi) && (ad_in <= pi_pkg::rom_end_hi);
    assign in_sram = (ad_in >= pi_pkg::sram_base_hi) && (ad_in <= pi_pkg::sram_end_hi);
    assign in_cfg  = (ad_in == pi_pkg::cfg_hi);

    always_ff @(posedge clk) begin
        if (!pi_reset) begin
            decode.read_port  <= pi_pkg::port_none;
            decode.write_port <= pi_pkg::port_none;
            reg_select        <= 1'b0;
        end else if (events.aleh_op) begin
            decode.read_port  <= pi_pkg::port_none;
            decode.write_port <= pi_pkg::port_none;
            decode.mem_offset <= '0;
            reg_select        <= 1'b0;

            // ROM maps down to the bottom of memory
            if (in_rom) begin
                decode.read_port  <= pi_pkg::port_mem;
                decode.write_port <= cfg.rom_write_enabled ? pi_pkg::port_mem
                                                           : pi_pkg::port_none;
                decode.mem_offset <= 32'd0 - {pi_pkg::rom_base_hi, 16'h0000};
            end

            if (cfg.sram_enabled && in_sram) begin
                decode.read_port  <= pi_pkg::port_mem;
                decode.write_port <= pi_pkg::port_mem;
                decode.mem_offset <= pi_pkg::save_offset - {pi_pkg::sram_base_hi, 16'h0000};
            end

            // Config registers stay writable even while locked
            if (in_cfg) begin
                decode.read_port  <= cfg.cfg_unlock ? pi_pkg::port_reg : pi_pkg::port_none;
                decode.write_port <= pi_pkg::port_reg;
                reg_select        <= 1'b1;
            end
        end
    end

endmodule

/* hw/pi_fifo.sv */
`timescale 1ns/1ps

module pi_fifo (
    input  logic        clk,
    input  logic        pi_reset,
    input  logic        flush,
    input  logic        write,
    input  logic [15:0] wdata,
    input  logic        read,
    output logic        full,
    output logic        empty,
    output logic [15:0] rdata
);

    logic [15:0] mem [pi_pkg::fifo_depth];

    // One extra pointer bit tells full from empty
    logic [pi_pkg::fifo_addr_w:0] wr_ptr;
    logic [pi_pkg::fifo_addr_w:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[pi_pkg::fifo_addr_w] != rd_ptr[pi_pkg::fifo_addr_w])
        && (wr_ptr[pi_pkg::fifo_addr_w-1:0] == rd_ptr[pi_pkg::fifo_addr_w-1:0]);
    assign rdata = mem[rd_ptr[pi_pkg::fifo_addr_w-1:0]];

    always_ff @(posedge clk) begin
        if (!pi_reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (write && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (read && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write && !full) begin
            mem[wr_ptr[pi_pkg::fifo_addr_w-1:0]] <= wdata;
        end
    end

endmodule

/* hw/pi_mem_ctrl.sv */
`timescale 1ns/1ps

module pi_mem_ctrl (
    input  logic               clk,
    input  logic               pi_reset,
    input  pi_pkg::pi_events_t events,
    input  logic               console_on,
    input  pi_pkg::pi_decode_t decode,
    input  logic [15:0]        ad_in,
    output pi_pkg::mem_req_t   mem_req,
    output logic [15:0]        mem_rdata,
    output logic               mem_rdata_valid,
    input  pi_pkg::mem_rsp_t   mem_rsp
);

    logic        read_fifo_write;
    logic        read_fifo_full;
    logic        read_fifo_empty;
    logic        read_wait;

    logic        write_fifo_write;
    logic [15:0] write_fifo_wdata;
    logic        write_fifo_full;
    logic        write_fifo_empty;
    logic [15:0] write_fifo_rdata;
    logic [15:0] write_word;
    logic        write_wait;

    logic [15:0] addr_hi;
    logic [31:0] start_address;
    logic        load_start;
    logic        read_enabled;
    logic        first_write;
    logic        write_grant;
    logic        read_grant;

    assign read_fifo_write = mem_rsp.ack && !mem_req.write;

    pi_fifo read_fifo_i (
        .clk      (clk),
        .pi_reset (pi_reset),
        .flush    (!console_on || events.alel_op),
        .write    (read_fifo_write),
        .wdata    (mem_rsp.rdata),
        .read     (mem_rdata_valid),
        .full     (read_fifo_full),
        .empty    (read_fifo_empty),
        .rdata    (mem_rdata)
    );

    // Serve the console strobe now, or as soon as a prefetched word lands
    assign mem_rdata_valid = (decode.read_port == pi_pkg::port_mem) && !read_fifo_empty
        && (events.read_op || read_wait);

    always_ff @(posedge clk) begin
        if (!pi_reset || !console_on || events.alel_op) begin
            read_wait <= 1'b0;
        end else if (mem_rdata_valid) begin
            read_wait <= 1'b0;
        end else if (events.read_op && (decode.read_port == pi_pkg::port_mem)) begin
            read_wait <= 1'b1;
        end
    end

    assign write_fifo_write = (decode.write_port == pi_pkg::port_mem) && !write_fifo_full
        && (events.write_op || write_wait);
    assign write_fifo_wdata = write_wait ? write_word : ad_in;

    pi_fifo write_fifo_i (
        .clk      (clk),
        .pi_reset (pi_reset),
        .flush    (!console_on),
        .write    (write_fifo_write),
        .wdata    (write_fifo_wdata),
        .read     (write_grant),
        .full     (write_fifo_full),
        .empty    (write_fifo_empty),
        .rdata    (write_fifo_rdata)
    );

    always_ff @(posedge clk) begin
        if (events.write_op) begin
            write_word <= ad_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!pi_reset || !console_on) begin
            write_wait <= 1'b0;
        end else if (write_fifo_write) begin
            write_wait <= 1'b0;
        end else if (events.write_op && (decode.write_port == pi_pkg::port_mem)) begin
            write_wait <= 1'b1;
        end
    end

    // Writes win over prefetch and only one request is in flight
    assign write_grant = !mem_req.request && !write_fifo_empty;
    assign read_grant  = !mem_req.request && !write_grant && read_enabled
        && (decode.read_port == pi_pkg::port_mem) && !read_fifo_full;

    always_ff @(posedge clk) begin
        if (!pi_reset || !console_on) begin
            mem_req.request <= 1'b0;
            load_start      <= 1'b0;
            read_enabled    <= 1'b0;
            first_write     <= 1'b0;
        end else begin
            load_start <= events.alel_op;

            if (events.aleh_op) begin
                addr_hi <= ad_in;
            end
            if (events.alel_op) begin
                start_address <= {addr_hi, ad_in} + decode.mem_offset;
                read_enabled  <= 1'b0;
                first_write   <= 1'b1;
            end
            if (load_start) begin
                mem_req.address <= start_address;
                read_enabled    <= 1'b1;
            end

            if (write_grant) begin
                mem_req.request <= 1'b1;
                mem_req.write   <= 1'b1;
                mem_req.wdata   <= write_fifo_rdata;
                read_enabled    <= 1'b0;
                // Prefetch may already have moved the address
                if (first_write) begin
                    mem_req.address <= start_address;
                    first_write     <= 1'b0;
                end
            end else if (read_grant) begin
                mem_req.request <= 1'b1;
                mem_req.write   <= 1'b0;
            end

            if (mem_rsp.ack) begin
                mem_req.request       <= 1'b0;
                mem_req.address[16:0] <= mem_req.address[16:0] + 17'd2;
            end

            if (events.end_op) begin
                read_enabled <= 1'b0;
            end
        end
    end

endmodule

/* hw/pi_bus_port.sv */
`timescale 1ns/1ps

module pi_bus_port (
    input  logic               clk,
    input  logic               pi_reset,
    input  pi_pkg::pi_events_t events,
    input  pi_pkg::pi_mode_e   mode,
    input  logic               console_on,
    input  pi_pkg::pi_decode_t decode,
    input  logic               reg_select,
    input  logic [15:0]        mem_rdata,
    input  logic               mem_rdata_valid,
    input  logic [15:0]        reg_rdata,
    input  logic               pi_read,
    output logic [15:0]        ad_in,
    output pi_pkg::reg_req_t   reg_req,
    inout  wire  [15:0]        ad
);

    logic        oe_arm;
    logic [15:0] ad_out;
    logic [16:0] reg_address;
    logic        reg_read;
    logic        reg_write;
    logic [15:0] reg_wdata;

    // Let go of the bus the moment the console raises read
    assign ad = (oe_arm && !pi_read) ? ad_out : 16'hzzzz;

    assign reg_req = '{
        select:  reg_select,
        read:    reg_read,
        write:   reg_write,
        address: reg_address,
        wdata:   reg_wdata
    };

    always_ff @(posedge clk) begin
        ad_in     <= ad;
        reg_wdata <= ad_in;

        if (mem_rdata_valid) begin
            ad_out <= mem_rdata;
        end else if (events.read_op && (decode.read_port == pi_pkg::port_reg)) begin
            ad_out <= reg_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!pi_reset) begin
            oe_arm    <= 1'b0;
            reg_read  <= 1'b0;
            reg_write <= 1'b0;
        end else begin
            oe_arm <= console_on && (mode == pi_pkg::mode_valid)
                && (decode.read_port != pi_pkg::port_none);
            reg_read  <= events.read_op && (decode.read_port == pi_pkg::port_reg);
            reg_write <= events.write_op && (decode.write_port == pi_pkg::port_reg);
        end
    end

    // Register address is bit 0 of the high word plus the low word
    always_ff @(posedge clk) begin
        if (events.aleh_op) begin
            reg_address[16] <= ad_in[0];
        end
        if (events.alel_op) begin
            reg_address[15:0] <= ad_in;
        end
        if (reg_read || reg_write) begin
            reg_address <= reg_address + 17'd2;
        end
    end

endmodule

/* hw/pi_target.sv */
`timescale 1ns/1ps

module pi_target (
    input  logic             clk,
    input  logic             pi_reset,
    input  logic             n64_reset,
    input  logic             pi_aleh,
    input  logic             pi_alel,
    input  logic             pi_read,
    input  logic             pi_write,
    input  pi_pkg::pi_cfg_t  cfg,
    input  pi_pkg::mem_rsp_t mem_rsp,
    input  logic [15:0]      reg_rdata,
    output pi_pkg::mem_req_t mem_req,
    output pi_pkg::reg_req_t reg_req,
    inout  wire  [15:0]      ad
);

    pi_pkg::pi_events_t events;
    pi_pkg::pi_mode_e   mode;
    pi_pkg::pi_decode_t decode;
    logic               console_on;
    logic               reg_select;
    logic [15:0]        ad_in;
    logic [15:0]        mem_rdata;
    logic               mem_rdata_valid;

    pi_sync_events sync_events_i (
        .clk        (clk),
        .pi_reset   (pi_reset),
        .n64_reset  (n64_reset),
        .pi_aleh    (pi_aleh),
        .pi_alel    (pi_alel),
        .pi_read    (pi_read),
        .pi_write   (pi_write),
        .events     (events),
        .console_on (console_on),
        .mode       (mode)
    );

    pi_addr_decode addr_decode_i (
        .clk        (clk),
        .pi_reset   (pi_reset),
        .events     (events),
        .ad_in      (ad_in),
        .cfg        (cfg),
        .decode     (decode),
        .reg_select (reg_select)
    );

    pi_mem_ctrl mem_ctrl_i (
        .clk             (clk),
        .pi_reset        (pi_reset),
        .events          (events),
        .console_on      (console_on),
        .decode          (decode),
        .ad_in           (ad_in),
        .mem_req         (mem_req),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid),
        .mem_rsp         (mem_rsp)
    );

    pi_bus_port bus_port_i (
        .clk             (clk),
        .pi_reset        (pi_reset),
        .events          (events),
        .mode            (mode),
        .console_on      (console_on),
        .decode          (decode),
        .reg_select      (reg_select),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid),
        .reg_rdata       (reg_rdata),
        .pi_read         (pi_read),
        .ad_in           (ad_in),
        .reg_req         (reg_req),
        .ad              (ad)
    );

endmodule

/* sim/pi_target_tb.sv */
`timescale 1ns/1ps

module pi_target_tb;

    // Roughly 30 accesses of 150 cycles each plus margin
    localparam int max_cycles = 6000;

    logic             clk;
    logic             pi_reset;
    logic             n64_reset;
    logic             pi_aleh;
    logic             pi_alel;
    logic             pi_read;
    logic             pi_write;
    pi_pkg::pi_cfg_t  cfg;
    pi_pkg::mem_rsp_t mem_rsp;
    logic [15:0]      reg_rdata;
    pi_pkg::mem_req_t mem_req;
    pi_pkg::reg_req_t reg_req;
    wire  [15:0]      ad;

    logic        bus_drive;
    logic [15:0] bus_word;
    logic        expect_float;
    logic [15:0] memory [logic [31:0]];
    logic [31:0] lfsr = 32'h2088;
    int unsigned delay;
    logic        serving;
    int          mem_requests = 0;
    int          mem_writes = 0;
    int          write_acks = 0;
    int          reg_reads = 0;
    int          reg_writes = 0;
    logic [16:0] last_reg_address;
    logic [15:0] last_reg_wdata;
    int          cycles = 0;

    // Console side of the shared bus
    assign ad = bus_drive ? bus_word : 16'hzzzz;

    pi_target dut_i (
        .clk       (clk),
        .pi_reset  (pi_reset),
        .n64_reset (n64_reset),
        .pi_aleh   (pi_aleh),
        .pi_alel   (pi_alel),
        .pi_read   (pi_read),
        .pi_write  (pi_write),
        .cfg       (cfg),
        .mem_rsp   (mem_rsp),
        .reg_rdata (reg_rdata),
        .mem_req   (mem_req),
        .reg_req   (reg_req),
        .ad        (ad)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else
            stop_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int unsigned draw_latency();
        int unsigned value;
        value = 0;
        for (int i = 0; i < 3; i++) begin
            value = (value << 1) | lfsr_bit();
        end
        return value;
    endfunction

    // Unwritten locations return a pattern of the whole address
    function automatic logic [15:0] model_word(input logic [31:0] address);
        if (memory.exists(address)) begin
            return memory[address];
        end
        return address[31:16] ^ address[15:0] ^ 16'h6C39;
    endfunction

    // Memory model serving one request at a time with 1 to 8 cycles of latency
    always @(posedge clk) begin
        mem_rsp.ack <= 1'b0;
        if (!pi_reset) begin
            serving <= 1'b0;
        end else if (mem_req.request && !mem_rsp.ack) begin
            if (!serving) begin
                serving      <= 1'b1;
                delay        <= draw_latency();
                mem_requests <= mem_requests + 1;
                mem_writes   <= mem_writes + mem_req.write;
            end else if (delay == 0) begin
                serving     <= 1'b0;
                mem_rsp.ack <= 1'b1;
                if (mem_req.write) begin
                    memory[mem_req.address] = mem_req.wdata;
                    write_acks <= write_acks + 1;
                end else begin
                    mem_rsp.rdata <= model_word(mem_req.address);
                end
            end else begin
                delay <= delay - 1;
            end
        end
    end

    // Register model and strobe monitor
    always @(posedge clk) begin
        reg_rdata <= reg_req.address[15:0] ^ 16'hA5A5;
        if (reg_req.read || reg_req.write) begin
            assert (reg_req.select) else stop_run("register strobe came without select");
        end
        if (reg_req.read) begin
            reg_reads <= reg_reads + 1;
        end
        if (reg_req.write) begin
            reg_writes       <= reg_writes + 1;
            last_reg_address <= reg_req.address;
            last_reg_wdata   <= reg_req.wdata;
        end
    end

    // No contention, and the DUT leaves ad alone while read is high
    always @(negedge clk) begin
        if (pi_reset && bus_drive) begin
            assert (ad === bus_word) else
                stop_run($sformatf("error at %0t: ad contention, ad is %h", $time, ad));
        end else if (pi_reset && (pi_read || expect_float)) begin
            assert (ad === 16'hzzzz) else
                stop_run($sformatf("error at %0t: ad driven to %h", $time, ad));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            stop_run($sformatf("Run hung, no end after %0d cycles", cycles));
        end
    end

    task automatic address_phase(input logic [31:0] address);
        bus_drive <= 1'b1;
        bus_word  <= address[31:16];
        pi_alel   <= 1'b1;
        repeat (12) @(posedge clk);
        bus_word <= address[15:0];
        pi_aleh  <= 1'b0;
        repeat (12) @(posedge clk);
        bus_drive <= 1'b0;
        pi_alel   <= 1'b0;
    endtask

    task automatic end_access();
        repeat (12) @(posedge clk);
        pi_aleh   <= 1'b1;
        bus_drive <= 1'b0;
        repeat (12) @(posedge clk);
    endtask

    // Sample half a cycle before the read strobe rises
    task automatic console_read(output logic [15:0] word);
        repeat (12) @(posedge clk);
        pi_read <= 1'b0;
        repeat (23) @(posedge clk);
        @(negedge clk);
        word = ad;
        @(posedge clk);
        pi_read <= 1'b1;
    endtask

    task automatic console_write(input logic [15:0] word);
        repeat (12) @(posedge clk);
        bus_drive <= 1'b1;
        bus_word  <= word;
        pi_write  <= 1'b0;
        repeat (12) @(posedge clk);
        pi_write <= 1'b1;
    endtask

    task automatic wait_for_writes(input int target);
        while (write_acks < target) begin
            @(posedge clk);
        end
    endtask

    initial begin
        logic [15:0] word;
        int          snap;
        int          snap_reg;
        pi_reset     = 1'b0;
        n64_reset    = 1'b1;
        pi_aleh      = 1'b1;
        pi_alel      = 1'b0;
        pi_read      = 1'b1;
        pi_write     = 1'b1;
        cfg          = '0;
        mem_rsp      = '0;
        reg_rdata    = '0;
        bus_drive    = 1'b0;
        bus_word     = '0;
        expect_float = 1'b0;
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_value({mem_req.request, reg_req.read, reg_req.write, reg_req.select}, 0,
                    "strobes in reset");
        @(posedge clk);
        pi_reset <= 1'b1;
        repeat (4) @(posedge clk);

        // ROM burst read maps 0x1000_0040 down to 0x40
        address_phase(32'h1000_0040);
        for (int i = 0; i < 4; i++) begin
            console_read(word);
            check_value(word, model_word(32'h40 + 2 * i), "ROM read word");
        end
        end_access();

        cfg.rom_write_enabled <= 1'b1;
        snap = write_acks;
        address_phase(32'h1000_0040);
        for (int i = 0; i < 4; i++) begin
            console_write(16'h1A00 + i);
        end
        end_access();
        wait_for_writes(snap + 4);
        for (int i = 0; i < 4; i++) begin
            check_value(model_word(32'h40 + 2 * i), 16'h1A00 + i, "ROM written word");
        end

        cfg.rom_write_enabled <= 1'b0;
        snap = mem_writes;
        address_phase(32'h1000_0040);
        console_write(16'h7700);
        console_write(16'h7701);
        end_access();
        check_value(mem_writes, snap, "write requests with ROM locked");
        check_value(model_word(32'h40), 16'h1A00, "ROM word after locked write");

        // Save RAM lands at the save offset
        cfg.sram_enabled <= 1'b1;
        snap = write_acks;
        address_phase(32'h0800_0010);
        console_write(16'h5100);
        console_write(16'h5101);
        end_access();
        wait_for_writes(snap + 2);
        for (int i = 0; i < 2; i++) begin
            check_value(model_word(pi_pkg::save_offset + 32'h10 + 2 * i), 16'h5100 + i,
                        "save RAM word");
        end
        address_phase(32'h0800_0010);
        for (int i = 0; i < 2; i++) begin
            console_read(word);
            check_value(word, 16'h5100 + i, "save RAM read back");
        end
        end_access();

        snap = reg_writes;
        address_phase(32'h1FFF_0020);
        console_write(16'hBEEF);
        end_access();
        check_value(reg_writes, snap + 1, "register write count");
        check_value(last_reg_address, 17'h1_0020, "register write address");
        check_value(last_reg_wdata, 16'hBEEF, "register write data");

        cfg.cfg_unlock <= 1'b1;
        snap = reg_reads;
        address_phase(32'h1FFF_0020);
        for (int i = 0; i < 2; i++) begin
            console_read(word);
            check_value(word, (16'h0020 + 2 * i) ^ 16'hA5A5, "register read word");
        end
        end_access();
        check_value(reg_reads, snap + 2, "register read count");

        // Locked config and unmapped windows must stay silent
        cfg.cfg_unlock <= 1'b0;
        snap_reg = reg_reads + reg_writes;
        address_phase(32'h1FFF_0020);
        expect_float = 1'b1;
        console_read(word);
        expect_float = 1'b0;
        end_access();
        check_value(reg_reads + reg_writes, snap_reg, "register strobes while locked");

        snap = mem_requests;
        address_phase(32'h0400_0000);
        expect_float = 1'b1;
        console_read(word);
        expect_float = 1'b0;
        console_write(16'h0BAD);
        end_access();
        check_value(mem_requests, snap, "memory requests in unmapped window");
        check_value(reg_reads + reg_writes, snap_reg, "register strobes in unmapped window");

        $display("TB PASSED");
        $finish;
    end

endmodule

/* sources.f */
hw/pi_pkg.sv
hw/pi_sync_events.sv
hw/pi_addr_decode.sv
hw/pi_fifo.sv
hw/pi_mem_ctrl.sv
hw/pi_bus_port.sv
hw/pi_target.sv
sim/pi_target_tb.sv
